/* include/mdu_defines.svh */
//////////////////////////////////////////////////
// width and operation code macros for the multiply/divide unit
// included by the package, the stages and the testbench
//////////////////////////////////////////////////

`ifndef MDU_DEFINES_SVH
`define MDU_DEFINES_SVH

// register width, 64 for an RV64 build
`define MDU_XLEN 32

// funct3 codes of the M extension
`define MDU_F3_MUL    3'd0
`define MDU_F3_MULH   3'd1
`define MDU_F3_MULHSU 3'd2
`define MDU_F3_MULHU  3'd3
`define MDU_F3_DIV    3'd4
`define MDU_F3_DIVU   3'd5
`define MDU_F3_REM    3'd6
`define MDU_F3_REMU   3'd7

`endif

/* hw/mdu_pkg.sv */
//////////////////////////////////////////////////
// vector types shared by the multiply/divide stages
// imported by wildcard in each module header
//////////////////////////////////////////////////

package mdu_pkg;

`include "mdu_defines.svh"

  //////////////////////////////////////////////////
  // data types
  //////////////////////////////////////////////////

  // one register word
  typedef logic [`MDU_XLEN-1:0] xlen_t;

  // full product of two register words
  typedef logic [2*`MDU_XLEN-1:0] dxlen_t;

  // operation code, taken from instruction funct3
  typedef logic [2:0] funct3_t;

  // most negative signed word
  // dividend of the signed overflow case and its quotient
  localparam xlen_t MDU_MOST_NEG = {1'b1, {(`MDU_XLEN-1){1'b0}}};

endpackage

/* hw/mdu_operand_stage.sv */
//////////////////////////////////////////////////
// stage 1 of the multiply/divide pipeline
// turns operands into magnitudes and sign flags, detects division corners
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mdu_defines.svh"

module mdu_operand_stage
  import mdu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // operation from the core
  input  logic    in_valid,
  input  funct3_t funct3,
  input  xlen_t   rs1,
  input  xlen_t   rs2,
  // towards the arithmetic stage
  output logic    s1_valid,
  output funct3_t s1_funct3,
  output xlen_t   s1_mag1,
  output xlen_t   s1_mag2,
  output logic    s1_neg_prod,
  output logic    s1_neg_quot,
  output logic    s1_neg_rem,
  output logic    s1_div_zero,
  output logic    s1_overflow,
  output xlen_t   s1_rs1
);

  // operand signedness per operation
  logic  rs1_signed;
  logic  rs2_signed;
  logic  is_div;
  // negative signed operands
  logic  neg1;
  logic  neg2;
  xlen_t mag1;
  xlen_t mag2;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  always_comb begin
    rs1_signed = 1'b0;
    rs2_signed = 1'b0;
    is_div     = 1'b0;
    case (funct3)
      `MDU_F3_MULH: begin
        rs1_signed = 1'b1;
        rs2_signed = 1'b1;
      end
      // only rs1 signed
      `MDU_F3_MULHSU: rs1_signed = 1'b1;
      `MDU_F3_DIV, `MDU_F3_REM: begin
        rs1_signed = 1'b1;
        rs2_signed = 1'b1;
        is_div     = 1'b1;
      end
      `MDU_F3_DIVU, `MDU_F3_REMU: is_div = 1'b1;
      // MUL and MULHU stay unsigned
      default: ;
    endcase
  end

  // two's complement magnitudes
  assign neg1 = rs1_signed & rs1[`MDU_XLEN-1];
  assign neg2 = rs2_signed & rs2[`MDU_XLEN-1];
  assign mag1 = neg1 ? ~rs1 + xlen_t'(1) : rs1;
  assign mag2 = neg2 ? ~rs2 + xlen_t'(1) : rs2;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // payload loads only with a valid operation
  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_funct3   <= funct3;
      s1_mag1     <= mag1;
      s1_mag2     <= mag2;
      s1_neg_prod <= neg1 ^ neg2;
      // quotient negative when signs differ
      s1_neg_quot <= neg1 ^ neg2;
      // remainder follows the dividend
      s1_neg_rem  <= neg1;
      s1_div_zero <= is_div & (rs2 == '0);
      // most negative by minus one, signed forms only
      s1_overflow <= is_div & rs2_signed & (rs1 == MDU_MOST_NEG) & (rs2 == '1);
      s1_rs1      <= rs1;
    end
  end

endmodule

/* hw/mdu_arith_stage.sv */
//////////////////////////////////////////////////
// stage 2 of the multiply/divide pipeline
// unsigned product, quotient and remainder of the operand magnitudes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mdu_arith_stage
  import mdu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // from the operand stage
  input  logic    s1_valid,
  input  funct3_t s1_funct3,
  input  xlen_t   s1_mag1,
  input  xlen_t   s1_mag2,
  input  logic    s1_neg_prod,
  input  logic    s1_neg_quot,
  input  logic    s1_neg_rem,
  input  logic    s1_div_zero,
  input  logic    s1_overflow,
  input  xlen_t   s1_rs1,
  // towards the result stage
  output logic    s2_valid,
  output funct3_t s2_funct3,
  output dxlen_t  s2_prod,
  output xlen_t   s2_quot,
  output xlen_t   s2_rem,
  output logic    s2_neg_prod,
  output logic    s2_neg_quot,
  output logic    s2_neg_rem,
  output logic    s2_div_zero,
  output logic    s2_overflow,
  output xlen_t   s2_rs1
);

  xlen_t  divisor;
  dxlen_t prod;
  xlen_t  quot;
  xlen_t  rem;

  // zero divisor replaced by one
  // result stage overrides quotient and remainder in that case
  assign divisor = (s1_mag2 == '0) ? xlen_t'(1) : s1_mag2;

  // full width product of the magnitudes
  assign prod = dxlen_t'(s1_mag1) * dxlen_t'(s1_mag2);

  // truncating unsigned division
  assign quot = s1_mag1 / divisor;
  assign rem  = s1_mag1 % divisor;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_funct3   <= s1_funct3;
      s2_prod     <= prod;
      s2_quot     <= quot;
      s2_rem      <= rem;
      // control passed along unchanged
      s2_neg_prod <= s1_neg_prod;
      s2_neg_quot <= s1_neg_quot;
      s2_neg_rem  <= s1_neg_rem;
      s2_div_zero <= s1_div_zero;
      s2_overflow <= s1_overflow;
      s2_rs1      <= s1_rs1;
    end
  end

endmodule

/* hw/mdu_result_stage.sv */
//////////////////////////////////////////////////
// stage 3 of the multiply/divide pipeline
// restores signs, applies corner results and selects rd
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mdu_defines.svh"

module mdu_result_stage
  import mdu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // from the arithmetic stage
  input  logic    s2_valid,
  input  funct3_t s2_funct3,
  input  dxlen_t  s2_prod,
  input  xlen_t   s2_quot,
  input  xlen_t   s2_rem,
  input  logic    s2_neg_prod,
  input  logic    s2_neg_quot,
  input  logic    s2_neg_rem,
  input  logic    s2_div_zero,
  input  logic    s2_overflow,
  input  xlen_t   s2_rs1,
  // result to the core
  output logic    out_valid,
  output xlen_t   rd
);

  dxlen_t prod_signed;
  xlen_t  quot_signed;
  xlen_t  rem_signed;
  xlen_t  quot_final;
  xlen_t  rem_final;
  xlen_t  rd_next;

  //////////////////////////////////////////////////
  // sign restore
  //////////////////////////////////////////////////

  assign prod_signed = s2_neg_prod ? ~s2_prod + dxlen_t'(1) : s2_prod;
  assign quot_signed = s2_neg_quot ? ~s2_quot + xlen_t'(1) : s2_quot;
  assign rem_signed  = s2_neg_rem  ? ~s2_rem  + xlen_t'(1) : s2_rem;

  // divide by zero gives all ones and the dividend
  // overflow gives the most negative value and zero
  always_comb begin
    if (s2_div_zero) begin
      quot_final = '1;
      rem_final  = s2_rs1;
    end else if (s2_overflow) begin
      quot_final = MDU_MOST_NEG;
      rem_final  = '0;
    end else begin
      quot_final = quot_signed;
      rem_final  = rem_signed;
    end
  end

  //////////////////////////////////////////////////
  // word select
  //////////////////////////////////////////////////

  always_comb begin
    case (s2_funct3)
      `MDU_F3_MUL: rd_next = prod_signed[`MDU_XLEN-1:0];
      // high word for all three MULH forms
      `MDU_F3_MULH, `MDU_F3_MULHSU, `MDU_F3_MULHU: begin
        rd_next = prod_signed[2*`MDU_XLEN-1:`MDU_XLEN];
      end
      `MDU_F3_DIV, `MDU_F3_DIVU: rd_next = quot_final;
      default: rd_next = rem_final;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s2_valid;
    end
  end

  // rd held until the next valid result
  always_ff @(posedge clk) begin
    if (s2_valid) begin
      rd <= rd_next;
    end
  end

endmodule

/* hw/mdu_top.sv */
//////////////////////////////////////////////////
// multiply/divide unit, three stage fixed latency pipeline
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mdu_top
  import mdu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  funct3_t funct3,
  input  xlen_t   rs1,
  input  xlen_t   rs2,
  output logic    out_valid,
  output xlen_t   rd
);

  // stage 1 outputs
  logic    s1_valid;
  funct3_t s1_funct3;
  xlen_t   s1_mag1;
  xlen_t   s1_mag2;
  logic    s1_neg_prod;
  logic    s1_neg_quot;
  logic    s1_neg_rem;
  logic    s1_div_zero;
  logic    s1_overflow;
  xlen_t   s1_rs1;

  // stage 2 outputs
  logic    s2_valid;
  funct3_t s2_funct3;
  dxlen_t  s2_prod;
  xlen_t   s2_quot;
  xlen_t   s2_rem;
  logic    s2_neg_prod;
  logic    s2_neg_quot;
  logic    s2_neg_rem;
  logic    s2_div_zero;
  logic    s2_overflow;
  xlen_t   s2_rs1;

  mdu_operand_stage mdu_operand_stage_inst (
    .clk, .rst_n, .in_valid, .funct3, .rs1, .rs2,
    .s1_valid, .s1_funct3, .s1_mag1, .s1_mag2, .s1_neg_prod,
    .s1_neg_quot, .s1_neg_rem, .s1_div_zero, .s1_overflow, .s1_rs1
  );

  mdu_arith_stage mdu_arith_stage_inst (
    .clk, .rst_n,
    .s1_valid, .s1_funct3, .s1_mag1, .s1_mag2, .s1_neg_prod,
    .s1_neg_quot, .s1_neg_rem, .s1_div_zero, .s1_overflow, .s1_rs1,
    .s2_valid, .s2_funct3, .s2_prod, .s2_quot, .s2_rem, .s2_neg_prod,
    .s2_neg_quot, .s2_neg_rem, .s2_div_zero, .s2_overflow, .s2_rs1
  );

  mdu_result_stage mdu_result_stage_inst (
    .clk, .rst_n,
    .s2_valid, .s2_funct3, .s2_prod, .s2_quot, .s2_rem, .s2_neg_prod,
    .s2_neg_quot, .s2_neg_rem, .s2_div_zero, .s2_overflow, .s2_rs1,
    .out_valid, .rd
  );

endmodule

/* sim/mdu_properties.sv */
//////////////////////////////////////////////////
// assertions on the valid pipeline of the multiply/divide unit
// bound to the top level from the testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mdu_properties
  import mdu_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  in_valid,
  input logic  out_valid,
  input xlen_t rd
);

  // no result while reset is held
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while reset is asserted");

  // fixed latency of three edges
  issue_latency: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> ##3 out_valid)
    else $error("no result three cycles after an issued operation");

  // a delivered result is fully known
  rd_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(rd))
    else $error("rd holds unknown bits while out_valid is high");

endmodule

/* sim/mdu_tb.sv */
//////////////////////////////////////////////////
// self-checking testbench for the multiply/divide unit
// directed vectors from the stimulus file, then seeded random vectors
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mdu_defines.svh"

module mdu_tb
  import mdu_pkg::*;
();

  localparam int RANDOM_COUNT = 200;
  localparam int MAX_DIRECTED = 64;

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  funct3_t funct3;
  xlen_t   rs1;
  xlen_t   rs2;
  logic    out_valid;
  xlen_t   rd;

  // directed vectors as read from the file
  funct3_t dir_f3 [MAX_DIRECTED];
  xlen_t   dir_rs1 [MAX_DIRECTED];
  xlen_t   dir_rs2 [MAX_DIRECTED];
  xlen_t   dir_rd [MAX_DIRECTED];
  int      dir_count = 0;

  // scoreboard, one entry per issued operation
  xlen_t   exp_q[$];
  funct3_t f3_q[$];
  xlen_t   rs1_q[$];
  xlen_t   rs2_q[$];
  int      cycle_q[$];

  int          cycle_count = 0;
  int          timeout_limit = 1000;
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          file_errors = 0;
  logic [31:0] rng_state;

  mdu_top mdu_top_inst (
    .clk, .rst_n, .in_valid, .funct3, .rs1, .rs2, .out_valid, .rd
  );

  bind mdu_top mdu_properties mdu_properties_inst (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid), .rd(rd)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // architectural result, exact product in 64 bits
  function automatic xlen_t reference_result(input funct3_t f3, input xlen_t a, input xlen_t b);
    logic [63:0] prod;
    longint      sa;
    longint      sb;
    longint      q;
    xlen_t       res;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (f3)
      `MDU_F3_MUL: begin
        prod = {32'b0, a} * {32'b0, b};
        res  = prod[31:0];
      end
      `MDU_F3_MULH: begin
        prod = sa * sb;
        res  = prod[63:32];
      end
      `MDU_F3_MULHSU: begin
        prod = sa * longint'({32'b0, b});
        res  = prod[63:32];
      end
      `MDU_F3_MULHU: begin
        prod = {32'b0, a} * {32'b0, b};
        res  = prod[63:32];
      end
      `MDU_F3_DIV: begin
        q   = (b == '0) ? -64'sd1 : sa / sb;
        // most negative over minus one wraps
        res = (a == 32'h80000000 && b == '1) ? 32'h80000000 : q[31:0];
      end
      `MDU_F3_DIVU: res = (b == '0) ? '1 : a / b;
      `MDU_F3_REM: begin
        q   = (b == '0) ? sa : sa % sb;
        res = (a == 32'h80000000 && b == '1) ? '0 : q[31:0];
      end
      default: res = (b == '0) ? a : a % b;
    endcase
    return res;
  endfunction

  task automatic load_directed();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    fd = $fopen("sim/mdu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/mdu_stimulus.txt");
      file_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // comment and blank lines fail the scan
      if (n > 0 && $sscanf(line, "%h %h %h %h", f, a, b, r) == 4) begin
        if (dir_count < MAX_DIRECTED) begin
          dir_f3[dir_count]  = f[2:0];
          dir_rs1[dir_count] = a;
          dir_rs2[dir_count] = b;
          dir_rd[dir_count]  = r;
          dir_count++;
        end
      end
    end
    $fclose(fd);
    if (dir_count == 0) begin
      $display("the stimulus file holds no vectors");
      file_errors++;
    end
  endtask

  // one operation per falling edge, expected value queued at issue
  task automatic issue(input funct3_t f3, input xlen_t a, input xlen_t b, input xlen_t expected);
    @(negedge clk);
    in_valid = 1'b1;
    funct3   = f3;
    rs1      = a;
    rs2      = b;
    exp_q.push_back(expected);
    f3_q.push_back(f3);
    rs1_q.push_back(a);
    rs2_q.push_back(b);
    cycle_q.push_back(cycle_count);
  endtask

  //////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles with %0d results pending", cycle_count, exp_q.size());
      $display("Simulation failed");
      $finish;
    end
  end

  // outputs sampled half a cycle after they change
  always @(negedge clk) begin : check_results
    xlen_t   expected;
    funct3_t f3;
    xlen_t   a;
    xlen_t   b;
    int      issued;
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("result at %0t with no operation pending", $time);
        protocol_errors++;
      end else begin
        expected = exp_q.pop_front();
        f3       = f3_q.pop_front();
        a        = rs1_q.pop_front();
        b        = rs2_q.pop_front();
        issued   = cycle_q.pop_front();
        if (rd !== expected) begin
          $display("CHECK FAILED at %0t: funct3 %0d rs1 %h rs2 %h expected %h got %h",
                   $time, f3, a, b, expected, rd);
          value_errors++;
        end
        // issue edge k, result edge k+3
        if (cycle_count - issued != 3) begin
          $display("result at %0t came %0d cycles after issue instead of 3",
                   $time, cycle_count - issued);
          protocol_errors++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int      i;
    funct3_t f3;
    xlen_t   a;
    xlen_t   b;
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    funct3    = '0;
    rs1       = '0;
    rs2       = '0;
    rng_state = 32'd92799;
    load_directed();
    timeout_limit = (dir_count + RANDOM_COUNT + 20) * 2;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // idle after reset, any result here is unexpected
    repeat (4) @(negedge clk);
    for (i = 0; i < dir_count; i++) begin
      issue(dir_f3[i], dir_rs1[i], dir_rs2[i], dir_rd[i]);
    end
    for (i = 0; i < RANDOM_COUNT; i++) begin
      rng_state = next_random(rng_state);
      f3        = rng_state[2:0];
      rng_state = next_random(rng_state);
      a         = rng_state;
      rng_state = next_random(rng_state);
      b         = rng_state;
      rng_state = next_random(rng_state);
      // small divisors, zero included, a quarter of the time
      if (rng_state[1:0] == 2'b00) begin
        b = b & 32'h0000000f;
      end
      issue(f3, a, b, reference_result(f3, a, b));
    end
    @(negedge clk);
    in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    $display("errors: %0d value, %0d protocol, %0d file",
             value_errors, protocol_errors, file_errors);
    if (value_errors + protocol_errors + file_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim/mdu_stimulus.txt */
// columns: funct3, rs1, rs2, expected rd, all hex
// funct3 0 to 3 are MUL, MULH, MULHSU, MULHU and 4 to 7 DIV, DIVU, REM, REMU
0 00000000 12345678 00000000
0 00000001 ffffffff ffffffff
0 ffffffff ffffffff 00000001
0 80000000 ffffffff 80000000
0 00001234 00005678 06260060
1 ffffffff ffffffff 00000000
1 80000000 80000000 40000000
1 80000000 00000001 ffffffff
2 ffffffff ffffffff ffffffff
2 80000000 ffffffff 80000000
2 00000002 ffffffff 00000001
3 ffffffff ffffffff fffffffe
4 00000007 00000002 00000003
4 fffffff9 00000002 fffffffd
4 00000007 fffffffe fffffffd
4 00000005 00000000 ffffffff
4 80000000 ffffffff 80000000
5 fffffff9 00000002 7ffffffc
5 00000005 00000000 ffffffff
6 fffffff9 00000002 ffffffff
6 00000007 fffffffe 00000001
6 80000000 ffffffff 00000000
6 fffffff9 00000000 fffffff9
7 fffffff9 00000002 00000001
7 00000005 00000000 00000005

/* verilog.f */
+incdir+include
hw/mdu_pkg.sv
hw/mdu_operand_stage.sv
hw/mdu_arith_stage.sv
hw/mdu_result_stage.sv
hw/mdu_top.sv
sim/mdu_properties.sv
sim/mdu_tb.sv

/* Makefile */
TOP := mdu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
